// ==== sim/lsu_stimulus.txt ====
# kind op1 op2 op3 size sign_ext wb_data exc, all hex; exc 1 TLB miss, 2 page fault
# kind 0 load, 1 store, 2 load kept as reference, 3 load equal to that reference
1 00000100 00000020 a1b2c3d4 3 0 00000000 0
0 00000120 00000000 00000000 3 0 a1b2c3d4 0
0 00000100 00000021 00000000 1 0 000000c3 0
0 00000123 00000000 00000000 1 1 ffffffa1 0
0 00000110 00000012 00000000 2 1 ffffa1b2 0
0 00000120 00000000 00000000 2 0 0000c3d4 0
1 00000122 00000000 0000005e 1 0 00000000 0
1 00000120 00000000 00007f01 2 0 00000000 0
0 00000120 00000000 00000000 3 0 a15e7f01 0
0 00000122 00000000 00000000 2 1 ffffa15e 0
0 00000120 00000000 00000000 2 1 00007f01 0
0 00000400 00000000 00000000 3 0 00000000 1
1 00000010 ffffffe0 11111111 3 0 00000000 1
2 00000300 00000000 00000000 3 0 00000000 0
1 00000300 00000000 12345678 3 0 00000000 2
3 00000300 00000000 00000000 3 0 00000000 0
1 000002f0 0000000c 89abcdef 3 0 00000000 0
0 000002ff 00000000 00000000 1 1 ffffff89 0
0 000002ff 00000000 00000000 1 0 00000089 0
0 000002fc 00000002 00000000 2 0 000089ab 0
1 000003ff 00000000 000000aa 1 0 00000000 2

// ==== compile.f ====
design/lsu_pkg.sv
design/lsu_agu.sv
design/lsu_dmmu.sv
design/lsu_ctrl.sv
design/lsu_dmem.sv
design/lsu_load_ext.sv
design/lsu_top.sv
sim/lsu_checker.sv
sim/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - files:
      - design/lsu_pkg.sv
      - design/lsu_agu.sv
      - design/lsu_dmmu.sv
      - design/lsu_ctrl.sv
      - design/lsu_dmem.sv
      - design/lsu_load_ext.sv
      - design/lsu_top.sv
  - target: simulation
    files:
      - sim/lsu_checker.sv
      - sim/lsu_tb.sv

// ==== sim/lsu_tb.sv ====
/* Testbench for the load/store unit; replays the stimulus file against
   the DUT with random write-back stalls */
`timescale 1ns/10ps

module lsu_tb;

   localparam int CLK_PERIOD = 10;
   localparam int RESET_CYCLES = 16;
   // Watchdog budget per operation
   localparam int CYCLES_PER_OP = 40;
   localparam int MAX_OPS = 64;

   logic clk;
   logic rst;
   logic in_valid;
   logic op_load;
   logic op_store;
   logic sign_ext;
   logic [2:0] size;
   logic [31:0] operand_1;
   logic [31:0] operand_2;
   logic [31:0] operand_3;
   logic wb_ready;
   logic flush_ack;
   logic in_ready;
   logic wb_valid;
   logic [31:0] wb_data;
   logic [31:0] lsa;
   logic exp_taken;
   logic [29:0] exp_tgt;

   // Expected values handed to the checker at issue
   logic exp_push;
   logic [1:0] exp_kind;
   logic [31:0] exp_wb;
   logic [1:0] exp_code;
   logic [31:0] exp_lsa;
   logic finished;
   int ops_done;
   int ops_failed;
   int stray_errors;

   // Operations as read from the file
   logic [1:0] st_kind [MAX_OPS];
   logic [31:0] st_op1 [MAX_OPS];
   logic [31:0] st_op2 [MAX_OPS];
   logic [31:0] st_op3 [MAX_OPS];
   logic [2:0] st_size [MAX_OPS];
   logic st_sign [MAX_OPS];
   logic [31:0] st_wb [MAX_OPS];
   logic [1:0] st_code [MAX_OPS];
   int n_ops;
   logic loaded;
   integer seed = 32'h4722_66fc;

   lsu_top DUT (
      .clk(clk), .rst(rst), .in_valid(in_valid), .op_load(op_load), .op_store(op_store),
      .sign_ext(sign_ext), .size(size), .operand_1(operand_1), .operand_2(operand_2),
      .operand_3(operand_3), .wb_ready(wb_ready), .flush_ack(flush_ack),
      .in_ready(in_ready), .wb_valid(wb_valid), .wb_data(wb_data), .lsa(lsa),
      .exp_taken(exp_taken), .exp_tgt(exp_tgt));

   lsu_checker u_checker (
      .clk(clk), .rst(rst), .exp_push(exp_push), .exp_kind(exp_kind), .exp_wb(exp_wb),
      .exp_code(exp_code), .exp_lsa(exp_lsa), .finished(finished), .in_ready(in_ready),
      .wb_valid(wb_valid), .wb_ready(wb_ready), .wb_data(wb_data), .lsa(lsa),
      .exp_taken(exp_taken), .flush_ack(flush_ack), .exp_tgt(exp_tgt),
      .ops_done(ops_done), .ops_failed(ops_failed), .stray_errors(stray_errors));

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Write-back stalls about one cycle in three
   always @(negedge clk) begin
      if (rst) begin
         wb_ready = 1'b1;
      end else begin
         wb_ready = ($unsigned($random(seed)) % 3) != 0;
      end
   end

   // Lines that do not hold eight hex fields are skipped
   task automatic read_stimulus();
      int fd;
      int got;
      logic [8*128-1:0] line_buf;
      logic [31:0] f_kind, f_op1, f_op2, f_op3, f_size, f_sign, f_wb, f_code;
      n_ops = 0;
      fd = $fopen("sim/lsu_stimulus.txt", "r");
      if (fd == 0) begin
         $display("could not open the stimulus file");
      end else begin
         while (!$feof(fd)) begin
            line_buf = '0;
            if ($fgets(line_buf, fd) != 0) begin
               got = $sscanf(line_buf, "%h %h %h %h %h %h %h %h", f_kind, f_op1, f_op2,
                             f_op3, f_size, f_sign, f_wb, f_code);
               if (got == 8 && n_ops < MAX_OPS) begin
                  st_kind[n_ops] = f_kind[1:0];
                  st_op1[n_ops] = f_op1;
                  st_op2[n_ops] = f_op2;
                  st_op3[n_ops] = f_op3;
                  st_size[n_ops] = f_size[2:0];
                  st_sign[n_ops] = f_sign[0];
                  st_wb[n_ops] = f_wb;
                  st_code[n_ops] = f_code[1:0];
                  n_ops++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // Starts at a falling edge, returns at the falling edge after completion
   task automatic run_op(input int idx);
      logic ack_due;
      logic done_op;
      ack_due = 1'b0;
      done_op = 1'b0;
      in_valid = 1'b1;
      op_load = (st_kind[idx] != 2'd1);
      op_store = (st_kind[idx] == 2'd1);
      sign_ext = st_sign[idx];
      size = st_size[idx];
      operand_1 = st_op1[idx];
      operand_2 = st_op2[idx];
      operand_3 = st_op3[idx];
      exp_push = 1'b1;
      exp_kind = st_kind[idx];
      exp_wb = st_wb[idx];
      exp_code = st_code[idx];
      // Effective address is the plain sum of the two address operands
      exp_lsa = st_op1[idx] + st_op2[idx];
      while (!done_op) begin
         @(posedge clk);
         if (in_ready === 1'b1) begin
            done_op = 1'b1;
         end else if (exp_taken === 1'b1) begin
            ack_due = 1'b1;
         end
         @(negedge clk);
         exp_push = 1'b0;
         flush_ack = ack_due && !done_op;
      end
      in_valid = 1'b0;
   endtask

   initial begin
      wait (loaded === 1'b1);
      #((n_ops * CYCLES_PER_OP + RESET_CYCLES) * CLK_PERIOD);
      $display("timeout: operations still running after %0d cycles",
               n_ops * CYCLES_PER_OP + RESET_CYCLES);
      $display("sim failed");
      $finish;
   end

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      in_valid = 1'b0;
      op_load = 1'b0;
      op_store = 1'b0;
      sign_ext = 1'b0;
      size = 3'd0;
      operand_1 = '0;
      operand_2 = '0;
      operand_3 = '0;
      wb_ready = 1'b1;
      flush_ack = 1'b0;
      exp_push = 1'b0;
      exp_kind = 2'd0;
      exp_wb = '0;
      exp_code = 2'd0;
      exp_lsa = '0;
      finished = 1'b0;
      loaded = 1'b0;
      read_stimulus();
      loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      for (int i = 0; i < n_ops; i++) begin
         run_op(i);
      end
      repeat (2) @(negedge clk);
      finished = 1'b1;
      #1;
      if (ops_done != n_ops || n_ops == 0) begin
         $display("%0d of %0d operations completed", ops_done, n_ops);
      end
      if (ops_failed == 0 && stray_errors == 0 && ops_done == n_ops && n_ops > 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== sim/lsu_checker.sv ====
/* Scoreboard for the load/store unit; checks each completion against
   its expected result and watches the write-back hold rules */
`timescale 1ns/10ps

module lsu_checker (
   input logic clk,
   input logic rst,
   // Expected result, one push per issued operation
   input logic exp_push,
   input logic [1:0] exp_kind,
   input logic [31:0] exp_wb,
   input logic [1:0] exp_code,
   input logic [31:0] exp_lsa,
   input logic finished,
   // Observed DUT ports
   input logic in_ready,
   input logic wb_valid,
   input logic wb_ready,
   input logic [31:0] wb_data,
   input logic [31:0] lsa,
   input logic exp_taken,
   input logic flush_ack,
   input logic [29:0] exp_tgt,
   output int ops_done,
   output int ops_failed,
   output int stray_errors
);

   // Operation kinds as coded in the stimulus file
   localparam logic [1:0] K_LOAD = 2'd0;
   localparam logic [1:0] K_REF = 2'd2;
   localparam logic [1:0] K_SAME = 2'd3;

   // Outstanding operations, oldest first
   logic [1:0] kind_q[$];
   logic [31:0] wb_q[$];
   logic [1:0] code_q[$];
   logic [31:0] lsa_q[$];

   // Errors seen for the operation at the head
   int op_errs;
   // Word read back from a page that no store can reach
   logic [31:0] ref_word;
   // Write-back was stalled at the previous edge
   logic held;
   logic [31:0] held_data;

   initial begin
      ops_done = 0;
      ops_failed = 0;
      stray_errors = 0;
      op_errs = 0;
      held = 1'b0;
   end

   task automatic protocol_error(input string what);
      if (kind_q.size() == 0) begin
         stray_errors++;
         $display("error outside any operation: %s", what);
      end else begin
         op_errs++;
         $display("op %0d: %s", ops_done + 1, what);
      end
   endtask

   task automatic value_error(input string sig, input logic [31:0] want,
                              input logic [31:0] got);
      op_errs++;
      $display("FAILED op %0d %s expected 0x%h got 0x%h", ops_done + 1, sig, want, got);
   endtask

   // Retire the head entry and print its line
   task automatic finish_op();
      void'(kind_q.pop_front());
      void'(wb_q.pop_front());
      void'(code_q.pop_front());
      void'(lsa_q.pop_front());
      ops_done++;
      if (op_errs == 0) begin
         $display("op %0d done, ok", ops_done);
      end else begin
         ops_failed++;
         $display("op %0d done, %0d error(s)", ops_done, op_errs);
      end
      op_errs = 0;
   endtask

   // Checks shared by both kinds of completion
   task automatic check_common();
      if (lsa !== lsa_q[0]) begin
         value_error("lsa", lsa_q[0], lsa);
      end
      if (in_ready !== 1'b1) begin
         protocol_error("in_ready stayed low at completion");
      end
   endtask

   task automatic check_writeback();
      case (kind_q[0])
         K_LOAD: begin
            if (wb_data !== wb_q[0]) begin
               value_error("wb_data", wb_q[0], wb_data);
            end
         end
         K_REF: begin
            ref_word = wb_data;
         end
         K_SAME: begin
            if (wb_data !== ref_word) begin
               value_error("wb_data", ref_word, wb_data);
            end
         end
         // Store response data is don't-care
         default: ;
      endcase
      check_common();
      finish_op();
   endtask

   task automatic check_flush();
      logic [29:0] want_tgt;
      if (code_q[0] == 2'd0) begin
         protocol_error("exception taken on an operation that should complete");
      end else begin
         // TLB-miss vector 0x100 and page-fault vector 0x200, shifted by 2
         want_tgt = (code_q[0] == 2'd1) ? 30'h40 : 30'h80;
         if (exp_tgt !== want_tgt) begin
            value_error("exp_tgt", {2'b00, want_tgt}, {2'b00, exp_tgt});
         end
      end
      check_common();
      finish_op();
   endtask

   always @(posedge clk) begin
      if (rst) begin
         held = 1'b0;
      end else begin
         if (exp_push === 1'b1) begin
            kind_q.push_back(exp_kind);
            wb_q.push_back(exp_wb);
            code_q.push_back(exp_code);
            lsa_q.push_back(exp_lsa);
         end
         // Stalled response must still be there, unchanged
         if (held) begin
            if (wb_valid !== 1'b1) begin
               protocol_error("write-back valid dropped while wb_ready was low");
            end else if (wb_data !== held_data) begin
               value_error("wb_data", held_data, wb_data);
            end
         end
         held = (wb_valid === 1'b1) && (wb_ready !== 1'b1);
         held_data = wb_data;
         if (held && in_ready === 1'b1) begin
            protocol_error("in_ready high while write-back is stalled");
         end
         if (wb_valid === 1'b1 && (kind_q.size() == 0 || code_q[0] != 2'd0)) begin
            protocol_error("write-back valid with no memory access outstanding");
         end else if (wb_valid === 1'b1 && wb_ready === 1'b1) begin
            check_writeback();
         end else if (exp_taken === 1'b1 && flush_ack === 1'b1) begin
            if (kind_q.size() == 0) begin
               protocol_error("flush acknowledged with no operation outstanding");
            end else begin
               check_flush();
            end
         end
      end
   end

   always @(posedge finished) begin
      $display("%0d ops checked: %0d passed, %0d failed, %0d other errors",
               ops_done, ops_done - ops_failed, ops_failed, stray_errors);
   end

endmodule

// ==== design/lsu_top.sv ====
/* Load/store unit top: address generation, page check, controller,
   data RAM and load extension */
`timescale 1ns/10ps

module lsu_top (
   input logic clk,
   input logic rst,
   input logic in_valid,
   input logic op_load,
   input logic op_store,
   input logic sign_ext,
   input logic [2:0] size,
   input logic [lsu_pkg::DW-1:0] operand_1,
   input logic [lsu_pkg::DW-1:0] operand_2,
   input logic [lsu_pkg::DW-1:0] operand_3,
   input logic wb_ready,
   input logic flush_ack,
   output logic in_ready,
   output logic wb_valid,
   output logic [lsu_pkg::DW-1:0] wb_data,
   output logic [lsu_pkg::AW-1:0] lsa,
   output logic exp_taken,
   output logic [lsu_pkg::AW-3:0] exp_tgt
);

   lsu_pkg::vaddr_u vaddr;
   logic mem_op;
   logic tlb_miss;
   logic page_fault;
   logic cmd_valid;
   logic cmd_ready;
   logic [lsu_pkg::AW-1:0] cmd_addr;
   logic [2:0] cmd_size;
   logic cmd_we;
   logic [lsu_pkg::DW-1:0] cmd_wdata;
   logic rsp_valid;
   logic [lsu_pkg::DW-1:0] rsp_data;

   // Valid load or store at the input
   assign mem_op = in_valid & (op_load | op_store);
   assign lsa = vaddr.raw;
   assign wb_valid = rsp_valid;

   lsu_agu u_agu (
      .operand_1(operand_1), .operand_2(operand_2), .operand_3(operand_3),
      .op_store(op_store), .size(size), .vaddr(vaddr), .cmd_addr(cmd_addr),
      .cmd_size(cmd_size), .cmd_we(cmd_we), .cmd_wdata(cmd_wdata));

   lsu_dmmu u_dmmu (
      .vaddr(vaddr), .op_valid(mem_op), .op_store(op_store),
      .tlb_miss(tlb_miss), .page_fault(page_fault));

   lsu_ctrl u_ctrl (
      .clk(clk), .rst(rst), .in_valid(mem_op), .tlb_miss(tlb_miss),
      .page_fault(page_fault), .cmd_ready(cmd_ready), .rsp_valid(rsp_valid),
      .rsp_ready(wb_ready), .flush_ack(flush_ack), .in_ready(in_ready),
      .cmd_valid(cmd_valid), .exp_taken(exp_taken), .exp_tgt(exp_tgt));

   // Write-back ready doubles as the response ready
   lsu_dmem u_dmem (
      .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd_addr(cmd_addr),
      .cmd_size(cmd_size), .cmd_we(cmd_we), .cmd_wdata(cmd_wdata),
      .rsp_ready(wb_ready), .cmd_ready(cmd_ready), .rsp_valid(rsp_valid),
      .rsp_data(rsp_data));

   lsu_load_ext u_load_ext (
      .rsp_data(rsp_data), .size(size), .sign_ext(sign_ext), .wb_data(wb_data));

endmodule

// ==== design/lsu_load_ext.sv ====
/* Load extension: widens byte and halfword loads to a full word,
   zero- or sign-filled */
`timescale 1ns/10ps

module lsu_load_ext (
   input logic [lsu_pkg::DW-1:0] rsp_data,
   input logic [2:0] size,
   input logic sign_ext,
   output logic [lsu_pkg::DW-1:0] wb_data
);

   // Fill bit for each sub-word size
   logic byte_fill;
   logic half_fill;

   assign byte_fill = sign_ext & rsp_data[7];
   assign half_fill = sign_ext & rsp_data[15];

   // Data arrives already shifted to bit 0 by the RAM
   always_comb begin
      case (size)
         lsu_pkg::SIZE_BYTE: begin
            wb_data = {{(lsu_pkg::DW - 8){byte_fill}}, rsp_data[7:0]};
         end
         lsu_pkg::SIZE_HALF: begin
            wb_data = {{(lsu_pkg::DW - 16){half_fill}}, rsp_data[15:0]};
         end
         // Full word, nothing to extend
         default: begin
            wb_data = rsp_data;
         end
      endcase
   end

endmodule

// ==== design/lsu_dmem.sv ====
/* Single-port data RAM with byte lanes behind a command/response bus;
   read data comes back with the addressed byte or halfword at bit 0 */
`timescale 1ns/10ps

module lsu_dmem (
   input logic clk,
   input logic rst,
   input logic cmd_valid,
   input logic [lsu_pkg::AW-1:0] cmd_addr,
   input logic [2:0] cmd_size,
   input logic cmd_we,
   input logic [lsu_pkg::DW-1:0] cmd_wdata,
   input logic rsp_ready,
   output logic cmd_ready,
   output logic rsp_valid,
   output logic [lsu_pkg::DW-1:0] rsp_data
);

   logic [lsu_pkg::DW-1:0] mem [0:lsu_pkg::MEM_WORDS-1];

   lsu_pkg::vaddr_u addr_v;
   logic [lsu_pkg::MEM_ABITS-3:0] word_idx;
   logic [1:0] byte_off;
   logic [3:0] byte_en;
   logic [lsu_pkg::DW-1:0] lane_wdata;
   logic hds_cmd;

   // Page fields give the word index directly
   assign addr_v.raw = cmd_addr;
   assign word_idx = {addr_v.page.vpn[lsu_pkg::PAGE_IDX_W-1:0],
                      addr_v.page.offset[lsu_pkg::PAGE_BITS-1:2]};
   assign byte_off = addr_v.page.offset[1:0];

   // Byte enables and replicated store data per size
   // Accesses are naturally aligned
   always_comb begin
      case (cmd_size)
         lsu_pkg::SIZE_BYTE: begin
            byte_en = 4'b0001 << byte_off;
            lane_wdata = {4{cmd_wdata[7:0]}};
         end
         lsu_pkg::SIZE_HALF: begin
            byte_en = 4'b0011 << {byte_off[1], 1'b0};
            lane_wdata = {2{cmd_wdata[15:0]}};
         end
         lsu_pkg::SIZE_WORD: begin
            byte_en = 4'b1111;
            lane_wdata = cmd_wdata;
         end
         default: begin
            byte_en = 4'b0000;
            lane_wdata = cmd_wdata;
         end
      endcase
   end

   // One response at a time
   assign cmd_ready = ~rsp_valid;
   assign hds_cmd = cmd_valid & cmd_ready;

   always_ff @(posedge clk) begin
      if (hds_cmd && cmd_we) begin
         for (int i = 0; i < 4; i++) begin
            if (byte_en[i]) begin
               mem[word_idx][8*i +: 8] <= lane_wdata[8*i +: 8];
            end
         end
      end
   end

   // Addressed lane lands at bit 0, data held until taken
   always_ff @(posedge clk) begin
      if (hds_cmd) begin
         rsp_data <= mem[word_idx] >> {byte_off, 3'b000};
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rsp_valid <= 1'b0;
      end else if (hds_cmd) begin
         rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
         rsp_valid <= 1'b0;
      end
   end

   // Response must not move under back-pressure
   a_rsp_stable: assert property (
      @(posedge clk) disable iff (rst)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
      else $error("response changed while stalled");

endmodule

// ==== design/lsu_ctrl.sv ====
/* Load/store controller: tracks the one outstanding memory command,
   raises exceptions for faulting operations and signals completion */
`timescale 1ns/10ps

module lsu_ctrl (
   input logic clk,
   input logic rst,
   input logic in_valid,
   input logic tlb_miss,
   input logic page_fault,
   input logic cmd_ready,
   input logic rsp_valid,
   input logic rsp_ready,
   input logic flush_ack,
   output logic in_ready,
   output logic cmd_valid,
   output logic exp_taken,
   output logic [lsu_pkg::AW-3:0] exp_tgt
);

   // A command is in flight and its response is not yet written back
   logic pending_r;
   logic pending_nxt;
   // Operation raised some data-side exception
   logic fault;
   // Handshakes
   logic hds_cmd;
   logic hds_wb;
   logic hds_exp;
   // Selected exception vector
   logic [lsu_pkg::VECT_DW-1:0] exp_vector;

   assign fault = tlb_miss | page_fault;

   assign hds_cmd = cmd_valid & cmd_ready;
   assign hds_wb = rsp_valid & rsp_ready;
   assign hds_exp = exp_taken & flush_ack;

   // Issue only a clean operation and only when nothing is in flight
   // The operation is held at the input until in_ready, so it must not
   // be sent a second time while pending
   assign cmd_valid = in_valid & ~fault & ~pending_r;

   // Set on command transfer, clear on write-back
   always_comb begin
      pending_nxt = pending_r;
      if (hds_cmd) begin
         pending_nxt = 1'b1;
      end else if (hds_wb) begin
         pending_nxt = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pending_r <= 1'b0;
      end else begin
         pending_r <= pending_nxt;
      end
   end

   // Faulting operation goes straight to the flush path
   // Level stays up while the operation is held, until flush_ack
   assign exp_taken = in_valid & fault;

   // Faults are mutually exclusive so an AND-OR mux is enough
   assign exp_vector = ({lsu_pkg::VECT_DW{tlb_miss}} & lsu_pkg::EDTM_VECTOR) |
                       ({lsu_pkg::VECT_DW{page_fault}} & lsu_pkg::EDPF_VECTOR);

   // Word-aligned target, vector shifted right by 2
   assign exp_tgt = {{(lsu_pkg::AW - lsu_pkg::VECT_DW){1'b0}},
                     exp_vector[lsu_pkg::VECT_DW-1:2]};

   // Completion is either the write-back handshake or the flush handshake
   assign in_ready = hds_wb | hds_exp;

   // A new command cannot go out in the cycle the old operation retires
   a_cmd_not_at_completion: assert property (
      @(posedge clk) disable iff (rst) !(hds_cmd && in_ready))
      else $error("command transfer in the completion cycle");

   // A held operation cannot start faulting after its command went out
   a_no_exp_while_pending: assert property (
      @(posedge clk) disable iff (rst) !(exp_taken && pending_r))
      else $error("exception raised with a command pending");

endmodule

// ==== design/lsu_dmmu.sv ====
/* Data MMU check against a fixed page map; flags a TLB miss for unmapped
   pages and a page fault for stores to read-only pages */
`timescale 1ns/10ps

module lsu_dmmu (
   input lsu_pkg::vaddr_u vaddr,
   input logic op_valid,
   input logic op_store,
   output logic tlb_miss,
   output logic page_fault
);

   // Page number of the access
   logic [lsu_pkg::AW-lsu_pkg::PAGE_BITS-1:0] vpn;
   // Index into the read-only mask
   logic [lsu_pkg::PAGE_IDX_W-1:0] page_idx;
   // Page lies inside the fixed map
   logic page_hit;
   // Page is marked read-only
   logic page_ro;

   assign vpn = vaddr.page.vpn;
   assign page_idx = vpn[lsu_pkg::PAGE_IDX_W-1:0];

   // Only the first NUM_PAGES pages have a translation
   assign page_hit = (vpn < lsu_pkg::NUM_PAGES);

   // Mask lookup only means something for a mapped page
   assign page_ro = lsu_pkg::PAGE_RO_MASK[page_idx];

   // No translation for the page
   assign tlb_miss = op_valid & ~page_hit;

   // Write permission violation
   // Loads from read-only pages are fine
   assign page_fault = op_valid & op_store & page_hit & page_ro;

   // The controller picks the vector with an AND-OR mux, so both faults
   // at once would merge two vectors into a bogus target
   always_comb begin
      assert final (!(tlb_miss && page_fault))
         else $error("dmmu raised TLB miss and page fault together");
   end

endmodule

// ==== design/lsu_agu.sv ====
/* Address generation: forms the effective address of a load or store
   and sets up the memory command from the issued operation */
`timescale 1ns/10ps

module lsu_agu (
   input logic [lsu_pkg::DW-1:0] operand_1,
   input logic [lsu_pkg::DW-1:0] operand_2,
   input logic [lsu_pkg::DW-1:0] operand_3,
   input logic op_store,
   input logic [2:0] size,
   output lsu_pkg::vaddr_u vaddr,
   output logic [lsu_pkg::AW-1:0] cmd_addr,
   output logic [2:0] cmd_size,
   output logic cmd_we,
   output logic [lsu_pkg::DW-1:0] cmd_wdata
);

   // Physical part of the address, identity map
   logic [lsu_pkg::MEM_ABITS-1:0] paddr;

   // Effective address is base plus displacement
   // Carry out of bit 31 is dropped
   always_comb begin
      vaddr.raw = operand_1 + operand_2;
   end

   // Only the RAM-backed low bits go to the memory
   // Page check happens in parallel on the full vaddr
   assign paddr = vaddr.raw[lsu_pkg::MEM_ABITS-1:0];

   assign cmd_addr = {{(lsu_pkg::AW - lsu_pkg::MEM_ABITS){1'b0}}, paddr};

   // Size code is passed through unchanged for loads and stores
   assign cmd_size = size;

   // Direction
   assign cmd_we = op_store;

   // Store data stays right-aligned here
   // The RAM moves it into its byte lanes
   assign cmd_wdata = operand_3;

endmodule

// ==== design/lsu_pkg.sv ====
/* Shared definitions of the load/store unit: widths, the data page map,
   the exception vectors and the two views of a virtual address */
package lsu_pkg;

   // Datapath widths
   localparam int unsigned DW = 32;
   localparam int unsigned AW = 32;

   // Page geometry, 64-byte pages
   localparam int unsigned PAGE_BITS = 6;
   localparam int unsigned NUM_PAGES = 16;
   localparam int unsigned PAGE_IDX_W = $clog2(NUM_PAGES);

   // Data RAM covers every mapped page
   localparam int unsigned MEM_ABITS = PAGE_IDX_W + PAGE_BITS;
   localparam int unsigned MEM_WORDS = 1 << (MEM_ABITS - 2);

   // One bit per page, set means read-only
   // Pages 12 to 15 take no stores
   localparam logic [NUM_PAGES-1:0] PAGE_RO_MASK = 16'hF000;

   // Access size codes, same encoding on the command bus
   localparam logic [2:0] SIZE_BYTE = 3'd1;
   localparam logic [2:0] SIZE_HALF = 3'd2;
   localparam logic [2:0] SIZE_WORD = 3'd3;

   // Exception vectors
   localparam int unsigned VECT_DW = 12;
   localparam logic [VECT_DW-1:0] EDTM_VECTOR = 12'h100;
   localparam logic [VECT_DW-1:0] EDPF_VECTOR = 12'h200;

   // Page number and byte offset within the page
   typedef struct packed {
      logic [AW-PAGE_BITS-1:0] vpn;
      logic [PAGE_BITS-1:0] offset;
   } vpage_t;

   // Virtual address seen as a raw word or split into page fields
   typedef union packed {
      logic [AW-1:0] raw;
      vpage_t page;
   } vaddr_u;

endpackage
